// File: verilog/audio_pkg.sv
package audio_pkg;

  // width of one audio sample in bits
  parameter int SAMPLE_W = 8;

  // signed audio sample as it arrives and as it is stored
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // default memory depth is 2**16 samples
  parameter int DEF_ADDR_W = 16;

  // default tap distances in samples, counted back from the playback address
  parameter int DEF_ECHO_DELAY_1 = 1500;
  parameter int DEF_ECHO_DELAY_2 = 3000;

  // each echo tap is shifted right by this much, so 1 gives half amplitude
  parameter int DEF_ECHO_SHIFT = 1;

  // one strobe starts a four-cycle read schedule, so strobes need at least this gap
  parameter int MIN_STROBE_GAP = 4;

  // codes on tap_sel that say which read the returning memory word belongs to
  parameter logic [1:0] TAP_MAIN  = 2'd0;
  parameter logic [1:0] TAP_ECHO1 = 2'd1;
  parameter logic [1:0] TAP_ECHO2 = 2'd2;

endpackage

// File: verilog/sample_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sample_ram #(
  parameter int ADDR_W = 16
) (
  input  logic                clk_in,
  input  logic [ADDR_W-1:0]   addr,
  input  logic                we,
  input  audio_pkg::sample_t  din,
  output audio_pkg::sample_t  dout
);

  localparam int DEPTH = 2 ** ADDR_W;

  audio_pkg::sample_t mem [DEPTH];

  // start from silence so that playback before any recording is defined
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // read-first port
  // a write and a read to the same address in one cycle return the old sample
  always_ff @(posedge clk_in) begin
    if (we) begin
      mem[addr] <= din;
    end
    dout <= mem[addr];
  end

endmodule

`default_nettype wire

// File: verilog/record_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module record_sequencer #(
  parameter int ADDR_W       = 16,
  parameter int ECHO_DELAY_1 = 1500,
  parameter int ECHO_DELAY_2 = 3000
) (
  input  logic                clk_in,
  input  logic                rst_in,
  input  audio_pkg::sample_t  audio_in,
  input  logic                audio_valid_in,
  input  logic                record_in,
  output logic [ADDR_W-1:0]   mem_addr,
  output logic                mem_we,
  output audio_pkg::sample_t  mem_din,
  output logic [1:0]          tap_sel,
  output logic                tap_valid
);

  // one strobe runs idle -> main -> echo 1 -> echo 2 and back to idle
  // which is why strobes must be MIN_STROBE_GAP cycles apart
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_MAIN  = 2'd1,
    ST_ECHO1 = 2'd2,
    ST_ECHO2 = 2'd3
  } state_t;

  state_t state;

  logic [ADDR_W-1:0] record_addr;
  logic [ADDR_W-1:0] record_len;
  logic [ADDR_W-1:0] play_addr;
  logic [ADDR_W-1:0] cap_addr;

  logic              strobe;
  logic [ADDR_W-1:0] record_next;
  logic [ADDR_W-1:0] len_next;
  logic [ADDR_W-1:0] play_step;

  // a strobe is only taken from idle, one arriving mid-schedule is dropped
  assign strobe = audio_valid_in && (state == ST_IDLE);

  assign record_next = record_addr + 1'b1;
  assign len_next    = record_in ? record_next : record_len;
  assign play_step   = play_addr + 1'b1;

  // the write happens in the strobe cycle itself, the reads in the three after it
  assign mem_we  = strobe && record_in;
  assign mem_din = audio_in;

  always_comb begin
    case (state)
      ST_MAIN:  mem_addr = cap_addr;
      ST_ECHO1: mem_addr = cap_addr - ADDR_W'(ECHO_DELAY_1);
      ST_ECHO2: mem_addr = cap_addr - ADDR_W'(ECHO_DELAY_2);
      default:  mem_addr = record_addr;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state       <= ST_IDLE;
      record_addr <= '0;
      record_len  <= '0;
      play_addr   <= '0;
      cap_addr    <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (strobe) begin
            cap_addr <= play_addr;
            // wrap playback once it runs past the end of the latest recording
            if (play_step >= len_next) begin
              play_addr <= '0;
            end else begin
              play_addr <= play_step;
            end
            if (record_in) begin
              record_addr <= record_next;
              record_len  <= record_next;
            end else begin
              // the next recording starts over at address 0
              record_addr <= '0;
            end
            state <= ST_MAIN;
          end
        end
        ST_MAIN:  state <= ST_ECHO1;
        ST_ECHO1: state <= ST_ECHO2;
        default:  state <= ST_IDLE;
      endcase
    end
  end

  // the memory answers one cycle later, so the tap markers trail by one cycle too
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      tap_sel   <= audio_pkg::TAP_MAIN;
      tap_valid <= 1'b0;
    end else begin
      tap_valid <= (state != ST_IDLE);
      case (state)
        ST_ECHO1: tap_sel <= audio_pkg::TAP_ECHO1;
        ST_ECHO2: tap_sel <= audio_pkg::TAP_ECHO2;
        default:  tap_sel <= audio_pkg::TAP_MAIN;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/echo_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module echo_mixer #(
  parameter int ECHO_SHIFT = 1
) (
  input  logic                clk_in,
  input  logic                rst_in,
  input  audio_pkg::sample_t  mem_dout,
  input  logic [1:0]          tap_sel,
  input  logic                tap_valid,
  output audio_pkg::sample_t  single_out,
  output audio_pkg::sample_t  echo_out,
  output logic                sample_valid
);

  // two extra bits hold the sum of three samples without overflow
  localparam int SUM_W   = audio_pkg::SAMPLE_W + 2;
  localparam int SAT_MAX = 2 ** (audio_pkg::SAMPLE_W - 1) - 1;
  localparam int SAT_MIN = -(2 ** (audio_pkg::SAMPLE_W - 1));

  audio_pkg::sample_t main_q;
  audio_pkg::sample_t echo1_q;

  logic signed [SUM_W-1:0] main_w;
  logic signed [SUM_W-1:0] tap1_w;
  logic signed [SUM_W-1:0] tap2_w;
  logic signed [SUM_W-1:0] sum;
  logic                    last_tap;

  // echo 2 is the last read of the schedule, the sum is formed as it arrives
  assign last_tap = tap_valid && (tap_sel == audio_pkg::TAP_ECHO2);

  assign main_w = main_q;
  assign tap1_w = echo1_q >>> ECHO_SHIFT;
  assign tap2_w = mem_dout >>> ECHO_SHIFT;
  assign sum    = main_w + tap1_w + tap2_w;

  always_ff @(posedge clk_in) begin
    if (tap_valid && (tap_sel == audio_pkg::TAP_MAIN)) begin
      main_q <= mem_dout;
    end
    if (tap_valid && (tap_sel == audio_pkg::TAP_ECHO1)) begin
      echo1_q <= mem_dout;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      single_out   <= '0;
      echo_out     <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= last_tap;
      if (last_tap) begin
        single_out <= main_q;
        // clamp instead of letting the sum wrap around
        if (sum > SAT_MAX) begin
          echo_out <= audio_pkg::sample_t'(SAT_MAX);
        end else if (sum < SAT_MIN) begin
          echo_out <= audio_pkg::sample_t'(SAT_MIN);
        end else begin
          echo_out <= audio_pkg::sample_t'(sum);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/audio_echo_top.sv
`timescale 1ns/1ps
`default_nettype none

module audio_echo_top #(
  parameter int ADDR_W       = audio_pkg::DEF_ADDR_W,
  parameter int ECHO_DELAY_1 = audio_pkg::DEF_ECHO_DELAY_1,
  parameter int ECHO_DELAY_2 = audio_pkg::DEF_ECHO_DELAY_2,
  parameter int ECHO_SHIFT   = audio_pkg::DEF_ECHO_SHIFT
) (
  input  logic                clk_in,
  input  logic                rst_in,
  input  audio_pkg::sample_t  audio_in,
  input  logic                audio_valid_in,
  input  logic                record_in,
  output audio_pkg::sample_t  single_out,
  output audio_pkg::sample_t  echo_out,
  output logic                sample_valid
);

  logic [ADDR_W-1:0]  mem_addr;
  logic               mem_we;
  audio_pkg::sample_t mem_din;
  audio_pkg::sample_t mem_dout;
  logic [1:0]         tap_sel;
  logic               tap_valid;

  // strobe to sample_valid is 5 cycles
  // the write and three reads take 4, the mixer register adds 1
  record_sequencer #(
    .ADDR_W       (ADDR_W),
    .ECHO_DELAY_1 (ECHO_DELAY_1),
    .ECHO_DELAY_2 (ECHO_DELAY_2)
  ) record_sequencer_inst (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .audio_in       (audio_in),
    .audio_valid_in (audio_valid_in),
    .record_in      (record_in),
    .mem_addr       (mem_addr),
    .mem_we         (mem_we),
    .mem_din        (mem_din),
    .tap_sel        (tap_sel),
    .tap_valid      (tap_valid)
  );

  sample_ram #(
    .ADDR_W (ADDR_W)
  ) sample_ram_inst (
    .clk_in (clk_in),
    .addr   (mem_addr),
    .we     (mem_we),
    .din    (mem_din),
    .dout   (mem_dout)
  );

  echo_mixer #(
    .ECHO_SHIFT (ECHO_SHIFT)
  ) echo_mixer_inst (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .mem_dout     (mem_dout),
    .tap_sel      (tap_sel),
    .tap_valid    (tap_valid),
    .single_out   (single_out),
    .echo_out     (echo_out),
    .sample_valid (sample_valid)
  );

endmodule

`default_nettype wire

// File: verif/audio_echo_asserts.sv
`timescale 1ns/1ps

module audio_echo_asserts (
  input logic               clk_in,
  input logic               rst_in,
  input logic               audio_valid_in,
  input logic               sample_valid,
  input audio_pkg::sample_t single_out,
  input audio_pkg::sample_t echo_out
);

  // number of failed assertions, read by the testbench at the end of the run
  int fail_count;

  // cycles since the last strobe, saturating at the minimum gap
  int gap_cnt;

  initial begin
    fail_count = 0;
  end

  always @(posedge clk_in) begin
    if (rst_in) begin
      gap_cnt <= audio_pkg::MIN_STROBE_GAP;
    end else if (audio_valid_in) begin
      gap_cnt <= 1;
    end else if (gap_cnt < audio_pkg::MIN_STROBE_GAP) begin
      gap_cnt <= gap_cnt + 1;
    end
  end

  strobe_gap_a: assert property (@(posedge clk_in) disable iff (rst_in)
    audio_valid_in |-> (gap_cnt >= audio_pkg::MIN_STROBE_GAP))
  else begin
    fail_count++;
    $error("audio_valid_in pulsed again before the minimum strobe gap");
  end

  // the fixed latency from strobe to output is 5 cycles
  valid_follows_strobe_a: assert property (@(posedge clk_in) disable iff (rst_in)
    $past(audio_valid_in, 5) |-> sample_valid)
  else begin
    fail_count++;
    $error("sample_valid missing 5 cycles after a strobe");
  end

  no_orphan_valid_a: assert property (@(posedge clk_in) disable iff (rst_in)
    sample_valid |-> $past(audio_valid_in, 5))
  else begin
    fail_count++;
    $error("sample_valid pulsed without a strobe 5 cycles earlier");
  end

  reset_values_a: assert property (@(posedge clk_in)
    rst_in |=> (!sample_valid && (single_out == '0) && (echo_out == '0)))
  else begin
    fail_count++;
    $error("outputs not cleared by reset");
  end

endmodule

// File: verif/echo_checker.sv
`timescale 1ns/1ps

module echo_checker #(
  parameter int ADDR_W       = 6,
  parameter int ECHO_DELAY_1 = 3,
  parameter int ECHO_DELAY_2 = 7,
  parameter int ECHO_SHIFT   = 1
) (
  input  logic               clk_in,
  input  logic               rst_in,
  input  audio_pkg::sample_t audio_in,
  input  logic               audio_valid_in,
  input  logic               record_in,
  input  audio_pkg::sample_t single_out,
  input  audio_pkg::sample_t echo_out,
  input  logic               sample_valid,
  output int                 out_count,
  output int                 error_count
);

  localparam int DEPTH   = 2 ** ADDR_W;
  localparam int SAT_MAX = 2 ** (audio_pkg::SAMPLE_W - 1) - 1;
  localparam int SAT_MIN = -(2 ** (audio_pkg::SAMPLE_W - 1));
  localparam int LATENCY = 5;

  // reference copy of the sample memory, silent at power-up like the DUT
  audio_pkg::sample_t ref_mem [DEPTH];

  int rec_addr;
  int rec_len;
  int play_addr;
  int cycle;

  int exp_single_q [$];
  int exp_echo_q [$];
  int strobe_cycle_q [$];

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      ref_mem[i] = '0;
    end
    out_count   = 0;
    error_count = 0;
    cycle       = 0;
  end

  // addresses wrap modulo the memory depth, also when going negative
  function automatic int wrap_addr(input int addr);
    return ((addr % DEPTH) + DEPTH) % DEPTH;
  endfunction

  function automatic int clamp_sample(input int value);
    if (value > SAT_MAX) begin
      return SAT_MAX;
    end
    if (value < SAT_MIN) begin
      return SAT_MIN;
    end
    return value;
  endfunction

  // the write lands before the reads of the same strobe, so a fresh sample is heard at once
  task automatic model_strobe();
    int p;
    int main_s;
    int tap1;
    int tap2;
    if (record_in) begin
      ref_mem[rec_addr] = audio_in;
      rec_addr = wrap_addr(rec_addr + 1);
      rec_len = rec_addr;
    end else begin
      rec_addr = 0;
    end
    p = play_addr;
    main_s = int'(ref_mem[p]);
    tap1 = int'(ref_mem[wrap_addr(p - ECHO_DELAY_1)]) >>> ECHO_SHIFT;
    tap2 = int'(ref_mem[wrap_addr(p - ECHO_DELAY_2)]) >>> ECHO_SHIFT;
    exp_single_q.push_back(main_s);
    exp_echo_q.push_back(clamp_sample(main_s + tap1 + tap2));
    strobe_cycle_q.push_back(cycle);
    play_addr = p + 1;
    if (play_addr >= rec_len) begin
      play_addr = 0;
    end
  endtask

  task automatic compare_output();
    int exp_s;
    int exp_e;
    int exp_c;
    if (exp_single_q.size() == 0) begin
      $display("%0t: sample_valid pulsed while no strobe was waiting for its output", $time);
      error_count++;
    end else begin
      exp_s = exp_single_q.pop_front();
      exp_e = exp_echo_q.pop_front();
      exp_c = strobe_cycle_q.pop_front();
      if (single_out !== audio_pkg::sample_t'(exp_s)) begin
        $display("[ERROR] %0t: single_out expected %0d, got %0d", $time, exp_s, single_out);
        error_count++;
      end
      if (echo_out !== audio_pkg::sample_t'(exp_e)) begin
        $display("[ERROR] %0t: echo_out expected %0d, got %0d", $time, exp_e, echo_out);
        error_count++;
      end
      if (cycle - exp_c != LATENCY) begin
        $display("[ERROR] %0t: sample_valid latency expected %0d, got %0d",
                 $time, LATENCY, cycle - exp_c);
        error_count++;
      end
    end
    out_count++;
  endtask

  always @(posedge clk_in) begin
    cycle++;
    if (rst_in) begin
      rec_addr  = 0;
      rec_len   = 0;
      play_addr = 0;
      exp_single_q.delete();
      exp_echo_q.delete();
      strobe_cycle_q.delete();
    end else begin
      if (sample_valid) begin
        compare_output();
      end
      if (audio_valid_in) begin
        model_strobe();
      end
    end
  end

endmodule

// File: verif/tb_audio_echo.sv
`timescale 1ns/1ps

module tb_audio_echo;

  localparam int ADDR_W        = 6;
  localparam int ECHO_DELAY_1  = 3;
  localparam int ECHO_DELAY_2  = 7;
  localparam int ECHO_SHIFT    = 1;
  localparam int NUM_ROWS      = 9;
  localparam int DRAIN_TIMEOUT = 40;

  // one row of stimulus with the number of outputs it must produce
  typedef struct packed {
    logic              record;
    logic [7:0]        count;
    logic [3:0]        gap;
    logic              random_src;
    logic signed [7:0] ramp_start;
    logic [7:0]        exp_outputs;
  } row_t;

  logic               clk_in;
  logic               rst_in;
  audio_pkg::sample_t audio_in;
  logic               audio_valid_in;
  logic               record_in;
  audio_pkg::sample_t single_out;
  audio_pkg::sample_t echo_out;
  logic               sample_valid;
  int                 out_count;
  int                 error_count;

  row_t rows [NUM_ROWS];

  audio_echo_top #(
    .ADDR_W       (ADDR_W),
    .ECHO_DELAY_1 (ECHO_DELAY_1),
    .ECHO_DELAY_2 (ECHO_DELAY_2),
    .ECHO_SHIFT   (ECHO_SHIFT)
  ) audio_echo_top_inst (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .audio_in       (audio_in),
    .audio_valid_in (audio_valid_in),
    .record_in      (record_in),
    .single_out     (single_out),
    .echo_out       (echo_out),
    .sample_valid   (sample_valid)
  );

  echo_checker #(
    .ADDR_W       (ADDR_W),
    .ECHO_DELAY_1 (ECHO_DELAY_1),
    .ECHO_DELAY_2 (ECHO_DELAY_2),
    .ECHO_SHIFT   (ECHO_SHIFT)
  ) echo_checker_inst (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .audio_in       (audio_in),
    .audio_valid_in (audio_valid_in),
    .record_in      (record_in),
    .single_out     (single_out),
    .echo_out       (echo_out),
    .sample_valid   (sample_valid),
    .out_count      (out_count),
    .error_count    (error_count)
  );

  bind audio_echo_top audio_echo_asserts audio_echo_asserts_inst (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .audio_valid_in (audio_valid_in),
    .sample_valid   (sample_valid),
    .single_out     (single_out),
    .echo_out       (echo_out)
  );

  initial begin
    clk_in = 1'b0;
  end

  always #5 clk_in = ~clk_in;

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // called 1 ns after an edge, returns 1 ns after the edge that ends the gap
  task automatic send_strobe(input audio_pkg::sample_t sample, input int gap);
    audio_in = sample;
    audio_valid_in = 1'b1;
    @(posedge clk_in);
    #1;
    audio_valid_in = 1'b0;
    for (int c = 1; c < gap; c++) begin
      @(posedge clk_in);
      #1;
    end
  endtask

  task automatic wait_outputs(input int target, output bit ok);
    int waited;
    waited = 0;
    while (out_count < target && waited < DRAIN_TIMEOUT) begin
      @(posedge clk_in);
      #1;
      waited++;
    end
    ok = (out_count >= target);
  endtask

  initial begin
    int                 sent;
    int                 row_start;
    int                 row_outputs;
    int                 tb_errors;
    int                 total;
    bit                 ok;
    bit                 timed_out;
    logic [31:0]        rng;
    audio_pkg::sample_t sample;

    audio_in       = '0;
    audio_valid_in = 1'b0;
    record_in      = 1'b0;
    rst_in         = 1'b1;

    // silence before any recording, then a long ramp that later shows up in the taps
    rows[0] = '{1'b0, 8'd4, 4'd6, 1'b0, 8'sd0, 8'd4};
    rows[1] = '{1'b1, 8'd60, 4'(audio_pkg::MIN_STROBE_GAP), 1'b0, -8'sd30, 8'd60};
    rows[2] = '{1'b0, 8'd70, 4'd5, 1'b0, 8'sd0, 8'd70};
    // random recording at the minimum gap, then its playback with large sums
    rows[3] = '{1'b1, 8'd24, 4'(audio_pkg::MIN_STROBE_GAP), 1'b1, 8'sd0, 8'd24};
    rows[4] = '{1'b0, 8'd30, 4'd4, 1'b0, 8'sd0, 8'd30};
    // a short loud recording whose echo taps reach back into the older ramp
    rows[5] = '{1'b1, 8'd9, 4'd6, 1'b0, 8'sd100, 8'd9};
    rows[6] = '{1'b0, 8'd20, 4'd5, 1'b0, 8'sd0, 8'd20};
    // a short recording from the bottom of the range drives the sum below -128
    rows[7] = '{1'b1, 8'd8, 4'(audio_pkg::MIN_STROBE_GAP), 1'b0, -8'sd128, 8'd8};
    rows[8] = '{1'b0, 8'd16, 4'd5, 1'b0, 8'sd0, 8'd16};

    rng       = 32'h8acb_affa;
    sent      = 0;
    tb_errors = 0;
    timed_out = 1'b0;

    repeat (5) @(posedge clk_in);
    #1;
    rst_in = 1'b0;

    for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
      row_start = out_count;
      record_in = rows[r].record;
      for (int i = 0; i < int'(rows[r].count); i++) begin
        if (rows[r].random_src) begin
          rng = xorshift32(rng);
          sample = audio_pkg::sample_t'(rng[7:0]);
        end else begin
          sample = audio_pkg::sample_t'(int'(rows[r].ramp_start) + i);
        end
        send_strobe(sample, int'(rows[r].gap));
        sent++;
      end
      wait_outputs(sent, ok);
      row_outputs = out_count - row_start;
      if (!ok) begin
        $display("%0t: row %0d timed out waiting for sample_valid, %0d of %0d outputs seen",
                 $time, r, row_outputs, int'(rows[r].count));
        tb_errors++;
        timed_out = 1'b1;
      end else if (row_outputs != int'(rows[r].exp_outputs)) begin
        $display("[ERROR] %0t: sample_valid count expected %0d, got %0d",
                 $time, int'(rows[r].exp_outputs), row_outputs);
        tb_errors++;
      end
      $display("row %0d done: record=%0d strobes=%0d gap=%0d outputs=%0d checker errors=%0d",
               r, rows[r].record, int'(rows[r].count), int'(rows[r].gap), row_outputs,
               error_count);
    end

    total = error_count + tb_errors + audio_echo_top_inst.audio_echo_asserts_inst.fail_count;
    $display("summary: %0d strobes, %0d outputs checked, %0d errors", sent, out_count, total);
    if (total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: project.f
verilog/audio_pkg.sv
verilog/sample_ram.sv
verilog/record_sequencer.sv
verilog/echo_mixer.sv
verilog/audio_echo_top.sv
verif/audio_echo_asserts.sv
verif/echo_checker.sv
verif/tb_audio_echo.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_audio_echo
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
